//--- Bender.yml
package:
  name: eop_shim

sources:
  - include_dirs:
      - hw
    files:
      - hw/mem_req_pkg.sv
      - hw/mem_rsp_pkg.sv
      - hw/req_len_table.sv
      - hw/flit_tracker.sv
      - hw/rsp_eop_stage.sv
      - hw/eop_shim_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/eop_shim_tb.sv

//--- dv/eop_shim_tb.sv
/* Testbench for the end-of-packet shim: clock and reset, random read and write
   packets with shuffled beats, reference counters, assertions and a watchdog */

`timescale 1ns/1ps

`include "eop_config.svh"

module eop_shim_tb
    import mem_req_pkg::*;
    import mem_rsp_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_PKTS     = 200;
    localparam int SWEEP_CYCLES = `EOP_MAX_ACTIVE_REQS;

    // Sweep and reset, then every packet at four beats on two channels with
    // a slack factor of three, plus a fixed margin
    localparam int WATCHDOG_CYCLES = SWEEP_CYCLES + 3 + NUM_PKTS * 4 * 2 * 3 + 500;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      rd_req_en;
    tag_t                      rd_req_tag;
    req_len_t                  rd_req_len;
    logic                      wr_req_en;
    tag_t                      wr_req_tag;
    req_len_t                  wr_req_len;
    logic                      mem_rd_alm_full;
    logic                      mem_wr_alm_full;
    logic                      user_rd_alm_full;
    logic                      user_wr_alm_full;
    logic                      mem_rd_rsp_valid;
    tag_t                      mem_rd_rsp_tag;
    cl_num_t                   mem_rd_rsp_cl_num;
    logic [`EOP_DATA_BITS-1:0] mem_rd_rsp_data;
    logic                      mem_wr_rsp_valid;
    tag_t                      mem_wr_rsp_tag;
    wr_fmt_e                   mem_wr_rsp_fmt;
    cl_num_t                   mem_wr_rsp_cl_num;
    logic                      user_rd_rsp_valid;
    tag_t                      user_rd_rsp_tag;
    cl_num_t                   user_rd_rsp_cl_num;
    logic [`EOP_DATA_BITS-1:0] user_rd_rsp_data;
    logic                      user_rd_rsp_eop;
    logic                      user_wr_rsp_valid;
    tag_t                      user_wr_rsp_tag;
    wr_fmt_e                   user_wr_rsp_fmt;
    cl_num_t                   user_wr_rsp_cl_num;

    // Expected outputs, set together with the stimulus that causes them
    logic                      exp_rd_valid = 1'b0;
    tag_t                      exp_rd_tag;
    cl_num_t                   exp_rd_cl;
    logic [`EOP_DATA_BITS-1:0] exp_rd_data;
    logic                      exp_rd_eop;
    logic                      exp_wr_valid = 1'b0;
    tag_t                      exp_wr_tag;
    cl_num_t                   exp_wr_cl;

    // The same values one cycle later, lined up with the DUT outputs
    logic                      rd_valid_q;
    tag_t                      rd_tag_q;
    cl_num_t                   rd_cl_q;
    logic [`EOP_DATA_BITS-1:0] rd_data_q;
    logic                      rd_eop_q;
    logic                      wr_valid_q;
    tag_t                      wr_tag_q;
    cl_num_t                   wr_cl_q;

    int sweep_cnt;
    int err_rd = 0;
    int err_wr = 0;
    int err_af = 0;

    eop_shim_top UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
    begin
        rd_valid_q <= exp_rd_valid;
        rd_tag_q   <= exp_rd_tag;
        rd_cl_q    <= exp_rd_cl;
        rd_data_q  <= exp_rd_data;
        rd_eop_q   <= exp_rd_eop;
        wr_valid_q <= exp_wr_valid;
        wr_tag_q   <= exp_wr_tag;
        wr_cl_q    <= exp_wr_cl;
    end

    // Cycles of the clearing sweep seen so far, one counter entry per cycle
    always @(posedge clk)
    begin
        if (reset)
        begin
            sweep_cnt <= 0;
        end
        else if (sweep_cnt < SWEEP_CYCLES)
        begin
            sweep_cnt <= sweep_cnt + 1;
        end
    end

    // ========================================================================
    // Output checks
    // ========================================================================

    assert property (@(posedge clk) disable iff (reset)
        user_rd_rsp_valid == rd_valid_q)
    else
    begin
        err_rd++;
        $display("FAIL %0t user_rd_rsp_valid: got %0b expected %0b",
            $time, $sampled(user_rd_rsp_valid), $sampled(rd_valid_q));
    end

    assert property (@(posedge clk) disable iff (reset)
        rd_valid_q |-> user_rd_rsp_tag == rd_tag_q)
    else
    begin
        err_rd++;
        $display("FAIL %0t user_rd_rsp_tag: got %0h expected %0h",
            $time, $sampled(user_rd_rsp_tag), $sampled(rd_tag_q));
    end

    assert property (@(posedge clk) disable iff (reset)
        rd_valid_q |-> user_rd_rsp_cl_num == rd_cl_q)
    else
    begin
        err_rd++;
        $display("FAIL %0t user_rd_rsp_cl_num: got %0d expected %0d",
            $time, $sampled(user_rd_rsp_cl_num), $sampled(rd_cl_q));
    end

    assert property (@(posedge clk) disable iff (reset)
        rd_valid_q |-> user_rd_rsp_data == rd_data_q)
    else
    begin
        err_rd++;
        $display("FAIL %0t user_rd_rsp_data: got %0h expected %0h",
            $time, $sampled(user_rd_rsp_data), $sampled(rd_data_q));
    end

    assert property (@(posedge clk) disable iff (reset)
        rd_valid_q |-> user_rd_rsp_eop == rd_eop_q)
    else
    begin
        err_rd++;
        $display("FAIL %0t user_rd_rsp_eop: got %0b expected %0b",
            $time, $sampled(user_rd_rsp_eop), $sampled(rd_eop_q));
    end

    // Only final write responses may reach the user, always in packed form
    assert property (@(posedge clk) disable iff (reset)
        user_wr_rsp_valid == wr_valid_q)
    else
    begin
        err_wr++;
        $display("FAIL %0t user_wr_rsp_valid: got %0b expected %0b",
            $time, $sampled(user_wr_rsp_valid), $sampled(wr_valid_q));
    end

    assert property (@(posedge clk) disable iff (reset)
        wr_valid_q |-> user_wr_rsp_tag == wr_tag_q)
    else
    begin
        err_wr++;
        $display("FAIL %0t user_wr_rsp_tag: got %0h expected %0h",
            $time, $sampled(user_wr_rsp_tag), $sampled(wr_tag_q));
    end

    assert property (@(posedge clk) disable iff (reset)
        wr_valid_q |-> user_wr_rsp_fmt == WR_FMT_PACKED)
    else
    begin
        err_wr++;
        $display("FAIL %0t user_wr_rsp_fmt: got %0b expected %0b",
            $time, $sampled(user_wr_rsp_fmt), WR_FMT_PACKED);
    end

    assert property (@(posedge clk) disable iff (reset)
        wr_valid_q |-> user_wr_rsp_cl_num == wr_cl_q)
    else
    begin
        err_wr++;
        $display("FAIL %0t user_wr_rsp_cl_num: got %0d expected %0d",
            $time, $sampled(user_wr_rsp_cl_num), $sampled(wr_cl_q));
    end

    // Almost-full is forced high for the whole sweep, then follows the memory
    assert property (@(posedge clk) disable iff (reset)
        user_rd_alm_full == (mem_rd_alm_full || sweep_cnt != SWEEP_CYCLES))
    else
    begin
        err_af++;
        $display("FAIL %0t user_rd_alm_full: got %0b expected %0b",
            $time, $sampled(user_rd_alm_full),
            $sampled(mem_rd_alm_full || sweep_cnt != SWEEP_CYCLES));
    end

    assert property (@(posedge clk) disable iff (reset)
        user_wr_alm_full == (mem_wr_alm_full || sweep_cnt != SWEEP_CYCLES))
    else
    begin
        err_af++;
        $display("FAIL %0t user_wr_alm_full: got %0b expected %0b",
            $time, $sampled(user_wr_alm_full),
            $sampled(mem_wr_alm_full || sweep_cnt != SWEEP_CYCLES));
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    // Random set bit of a four-bit mask, or -1 when the mask is empty
    function automatic int pick_bit(logic [3:0] mask);
        int start;
        int idx;
        start = $urandom_range(3);
        for (idx = 0; idx < 4; idx++)
        begin
            if (mask[(start + idx) % 4])
            begin
                return (start + idx) % 4;
            end
        end
        return -1;
    endfunction

    // Up to four open read packets, beats sent in random order
    task automatic run_rd_channel();
        logic [3:0] used;
        tag_t       s_tag [4];
        req_len_t   s_len [4];
        logic [3:0] s_left [4];
        logic       busy [`EOP_MAX_ACTIVE_REQS];
        int         rcvd [`EOP_MAX_ACTIVE_REQS];
        int         issued;
        int         slot;
        int         beat;
        int         t;
        tag_t       tag;
        used   = '0;
        issued = 0;
        for (t = 0; t < `EOP_MAX_ACTIVE_REQS; t++)
        begin
            busy[t] = 1'b0;
            rcvd[t] = 0;
        end
        while (issued < NUM_PKTS || used != '0)
        begin
            @(posedge clk);
            #1;
            rd_req_en        = 1'b0;
            mem_rd_rsp_valid = 1'b0;
            exp_rd_valid     = 1'b0;
            mem_rd_alm_full  = ($urandom_range(7) == 0);
            if (!mem_rd_alm_full && issued < NUM_PKTS && used != 4'hf
                && (used == '0 || $urandom_range(2) == 0))
            begin
                slot = pick_bit(~used);
                do
                    tag = tag_t'($urandom_range(`EOP_MAX_ACTIVE_REQS - 1));
                while (busy[tag]);
                busy[tag]    = 1'b1;
                used[slot]   = 1'b1;
                s_tag[slot]  = tag;
                s_len[slot]  = req_len_t'($urandom_range(3));
                s_left[slot] = 4'((1 << (int'(s_len[slot]) + 1)) - 1);
                issued++;
                rd_req_en  = 1'b1;
                rd_req_tag = tag;
                rd_req_len = s_len[slot];
            end
            else if (used != '0 && $urandom_range(3) != 0)
            begin
                slot = pick_bit(used);
                beat = pick_bit(s_left[slot]);
                tag  = s_tag[slot];
                s_left[slot][beat] = 1'b0;
                rcvd[tag] = rcvd[tag] + 1;
                mem_rd_rsp_valid  = 1'b1;
                mem_rd_rsp_tag    = tag;
                mem_rd_rsp_cl_num = cl_num_t'(beat);
                mem_rd_rsp_data   = {$urandom, $urandom};
                exp_rd_valid = 1'b1;
                exp_rd_tag   = tag;
                exp_rd_cl    = cl_num_t'(beat);
                exp_rd_data  = mem_rd_rsp_data;
                // The (length+1)th beat of a tag closes its packet
                exp_rd_eop   = (rcvd[tag] == int'(s_len[slot]) + 1);
                if (exp_rd_eop)
                begin
                    rcvd[tag]  = 0;
                    busy[tag]  = 1'b0;
                    used[slot] = 1'b0;
                end
            end
        end
        @(posedge clk);
        #1;
        mem_rd_rsp_valid = 1'b0;
        exp_rd_valid     = 1'b0;
    endtask

    // Write packets, about a third of them answered by one packed response
    task automatic run_wr_channel();
        logic [3:0] used;
        tag_t       s_tag [4];
        req_len_t   s_len [4];
        logic [3:0] s_left [4];
        logic       s_packed [4];
        logic       busy [`EOP_MAX_ACTIVE_REQS];
        int         rcvd [`EOP_MAX_ACTIVE_REQS];
        int         issued;
        int         slot;
        int         beat;
        int         t;
        tag_t       tag;
        used   = '0;
        issued = 0;
        for (t = 0; t < `EOP_MAX_ACTIVE_REQS; t++)
        begin
            busy[t] = 1'b0;
            rcvd[t] = 0;
        end
        while (issued < NUM_PKTS || used != '0)
        begin
            @(posedge clk);
            #1;
            wr_req_en        = 1'b0;
            mem_wr_rsp_valid = 1'b0;
            exp_wr_valid     = 1'b0;
            mem_wr_alm_full  = ($urandom_range(7) == 0);
            if (!mem_wr_alm_full && issued < NUM_PKTS && used != 4'hf
                && (used == '0 || $urandom_range(2) == 0))
            begin
                slot = pick_bit(~used);
                do
                    tag = tag_t'($urandom_range(`EOP_MAX_ACTIVE_REQS - 1));
                while (busy[tag]);
                busy[tag]      = 1'b1;
                used[slot]     = 1'b1;
                s_tag[slot]    = tag;
                s_len[slot]    = req_len_t'($urandom_range(3));
                s_left[slot]   = 4'((1 << (int'(s_len[slot]) + 1)) - 1);
                s_packed[slot] = ($urandom_range(2) == 0);
                issued++;
                wr_req_en  = 1'b1;
                wr_req_tag = tag;
                wr_req_len = s_len[slot];
            end
            else if (used != '0 && $urandom_range(3) != 0)
            begin
                slot = pick_bit(used);
                tag  = s_tag[slot];
                mem_wr_rsp_valid = 1'b1;
                mem_wr_rsp_tag   = tag;
                if (s_packed[slot])
                begin
                    mem_wr_rsp_fmt    = WR_FMT_PACKED;
                    mem_wr_rsp_cl_num = cl_num_t'(s_len[slot]);
                end
                else
                begin
                    beat = pick_bit(s_left[slot]);
                    s_left[slot][beat] = 1'b0;
                    rcvd[tag] = rcvd[tag] + 1;
                    mem_wr_rsp_fmt    = WR_FMT_BEAT;
                    mem_wr_rsp_cl_num = cl_num_t'(beat);
                end
                // Only the response that completes the packet reaches the user
                if (s_packed[slot] || rcvd[tag] == int'(s_len[slot]) + 1)
                begin
                    exp_wr_valid = 1'b1;
                    exp_wr_tag   = tag;
                    exp_wr_cl    = cl_num_t'(s_len[slot]);
                    rcvd[tag]    = 0;
                    busy[tag]    = 1'b0;
                    used[slot]   = 1'b0;
                end
            end
        end
        @(posedge clk);
        #1;
        mem_wr_rsp_valid = 1'b0;
        exp_wr_valid     = 1'b0;
    endtask

    initial
    begin
        // One seed for the whole run
        void'($urandom(32'h7915));
        reset             = 1'b1;
        rd_req_en         = 1'b0;
        rd_req_tag        = '0;
        rd_req_len        = '0;
        wr_req_en         = 1'b0;
        wr_req_tag        = '0;
        wr_req_len        = '0;
        mem_rd_alm_full   = 1'b0;
        mem_wr_alm_full   = 1'b0;
        mem_rd_rsp_valid  = 1'b0;
        mem_rd_rsp_tag    = '0;
        mem_rd_rsp_cl_num = '0;
        mem_rd_rsp_data   = '0;
        mem_wr_rsp_valid  = 1'b0;
        mem_wr_rsp_tag    = '0;
        mem_wr_rsp_fmt    = WR_FMT_BEAT;
        mem_wr_rsp_cl_num = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Requests are held off until both clearing sweeps are over
        wait (!user_rd_alm_full && !user_wr_alm_full);
        fork
            run_rd_channel();
            run_wr_channel();
        join
        repeat (3) @(posedge clk);

        $display("Error count: read %0d, write %0d, almost-full %0d", err_rd, err_wr, err_af);
        if (err_rd + err_wr + err_af == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog against a stuck run
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Error count: read %0d, write %0d, almost-full %0d", err_rd, err_wr, err_af);
        $display("Errors found");
        $finish;
    end

endmodule

//--- hw/eop_config.svh
/* Build-time sizes for the end-of-packet shim: tag count, tag width, packet
   length width and read data width */

`ifndef EOP_CONFIG_SVH
`define EOP_CONFIG_SVH

// Number of distinct request tags that may be in flight on one channel
`define EOP_MAX_ACTIVE_REQS 128

// Tag width, which must cover EOP_MAX_ACTIVE_REQS entries
`define EOP_TAG_BITS 7

// Width of a packet length or beat number
// Lengths are stored as beats minus one, so two bits cover one to four lines
`define EOP_LEN_BITS 2

// Width of one read data beat
`define EOP_DATA_BITS 64

`endif

//--- hw/eop_shim_top.sv
/* End-of-packet shim top level: request length tables and beat trackers
   for the read and write channels, joined by the shared response stage */

`timescale 1ns/1ps

`include "eop_config.svh"

module eop_shim_top
    import mem_req_pkg::*;
    import mem_rsp_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    // Requests leaving the user logic
    input  logic                      rd_req_en,
    input  tag_t                      rd_req_tag,
    input  req_len_t                  rd_req_len,
    input  logic                      wr_req_en,
    input  tag_t                      wr_req_tag,
    input  req_len_t                  wr_req_len,

    // Almost-full levels from the memory and toward the user
    input  logic                      mem_rd_alm_full,
    input  logic                      mem_wr_alm_full,
    output logic                      user_rd_alm_full,
    output logic                      user_wr_alm_full,

    // Responses from the memory
    input  logic                      mem_rd_rsp_valid,
    input  tag_t                      mem_rd_rsp_tag,
    input  cl_num_t                   mem_rd_rsp_cl_num,
    input  logic [`EOP_DATA_BITS-1:0] mem_rd_rsp_data,
    input  logic                      mem_wr_rsp_valid,
    input  tag_t                      mem_wr_rsp_tag,
    input  wr_fmt_e                   mem_wr_rsp_fmt,
    input  cl_num_t                   mem_wr_rsp_cl_num,

    // Responses toward the user
    output logic                      user_rd_rsp_valid,
    output tag_t                      user_rd_rsp_tag,
    output cl_num_t                   user_rd_rsp_cl_num,
    output logic [`EOP_DATA_BITS-1:0] user_rd_rsp_data,
    output logic                      user_rd_rsp_eop,
    output logic                      user_wr_rsp_valid,
    output tag_t                      user_wr_rsp_tag,
    output wr_fmt_e                   user_wr_rsp_fmt,
    output cl_num_t                   user_wr_rsp_cl_num
);

    req_len_t rd_len;
    req_len_t wr_len;
    logic     rd_eop;
    logic     wr_eop;
    logic     wr_beat_en;

    // ========================================================================
    // Read channel, every beat is counted
    // ========================================================================

    req_len_table rd_len_table (
        .clk     (clk),
        .req_en  (rd_req_en),
        .req_tag (rd_req_tag),
        .req_len (rd_req_len),
        .rsp_tag (mem_rd_rsp_tag),
        .rsp_len (rd_len)
    );

    flit_tracker rd_tracker (
        .clk           (clk),
        .reset         (reset),
        .rsp_en        (mem_rd_rsp_valid),
        .rsp_tag       (mem_rd_rsp_tag),
        .rsp_len       (rd_len),
        .mem_alm_full  (mem_rd_alm_full),
        .user_alm_full (user_rd_alm_full),
        .pkt_eop       (rd_eop)
    );

    // ========================================================================
    // Write channel, only per-beat responses are counted
    // ========================================================================

    req_len_table wr_len_table (
        .clk     (clk),
        .req_en  (wr_req_en),
        .req_tag (wr_req_tag),
        .req_len (wr_req_len),
        .rsp_tag (mem_wr_rsp_tag),
        .rsp_len (wr_len)
    );

    flit_tracker wr_tracker (
        .clk           (clk),
        .reset         (reset),
        .rsp_en        (wr_beat_en),
        .rsp_tag       (mem_wr_rsp_tag),
        .rsp_len       (wr_len),
        .mem_alm_full  (mem_wr_alm_full),
        .user_alm_full (user_wr_alm_full),
        .pkt_eop       (wr_eop)
    );

    // Shared output registers for both channels
    rsp_eop_stage rsp_stage (
        .clk                (clk),
        .reset              (reset),
        .mem_rd_rsp_valid   (mem_rd_rsp_valid),
        .mem_rd_rsp_tag     (mem_rd_rsp_tag),
        .mem_rd_rsp_cl_num  (mem_rd_rsp_cl_num),
        .mem_rd_rsp_data    (mem_rd_rsp_data),
        .rd_eop             (rd_eop),
        .mem_wr_rsp_valid   (mem_wr_rsp_valid),
        .mem_wr_rsp_tag     (mem_wr_rsp_tag),
        .mem_wr_rsp_fmt     (mem_wr_rsp_fmt),
        .mem_wr_rsp_cl_num  (mem_wr_rsp_cl_num),
        .wr_eop             (wr_eop),
        .wr_len             (wr_len),
        .wr_beat_en         (wr_beat_en),
        .user_rd_rsp_valid  (user_rd_rsp_valid),
        .user_rd_rsp_tag    (user_rd_rsp_tag),
        .user_rd_rsp_cl_num (user_rd_rsp_cl_num),
        .user_rd_rsp_data   (user_rd_rsp_data),
        .user_rd_rsp_eop    (user_rd_rsp_eop),
        .user_wr_rsp_valid  (user_wr_rsp_valid),
        .user_wr_rsp_tag    (user_wr_rsp_tag),
        .user_wr_rsp_fmt    (user_wr_rsp_fmt),
        .user_wr_rsp_cl_num (user_wr_rsp_cl_num)
    );

endmodule

//--- hw/flit_tracker.sv
/* Per-tag beat tracker: counts received response beats in a RAM that is
   swept clear after reset, flags the last beat and gates almost-full */

`timescale 1ns/1ps

`include "eop_config.svh"

module flit_tracker
    import mem_req_pkg::*;
    import mem_rsp_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Counted response beat with its tag and the packet length of that tag
    input  logic     rsp_en,
    input  tag_t     rsp_tag,
    input  req_len_t rsp_len,

    // Almost-full level from the memory, and the level shown to the user
    input  logic     mem_alm_full,
    output logic     user_alm_full,

    // High in the response cycle when this beat completes its packet
    output logic     pkt_eop
);

    // ========================================================================
    // Clearing sweep
    // ========================================================================

    trk_state_e state;
    tag_t       clear_idx;
    logic       sweep_last;

    // Last entry of the sweep, reached EOP_MAX_ACTIVE_REQS cycles after reset
    assign sweep_last = (clear_idx == tag_t'(`EOP_MAX_ACTIVE_REQS - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= TRK_CLEAR;
            clear_idx <= '0;
        end
        else if (state == TRK_CLEAR)
        begin
            // One entry is zeroed per cycle
            clear_idx <= clear_idx + tag_t'(1);
            if (sweep_last)
            begin
                state <= TRK_READY;
            end
        end
    end

    // The user must hold off new requests until every counter is known zero
    assign user_alm_full = mem_alm_full || (state != TRK_READY);

    // ========================================================================
    // Received-beat counters
    // ========================================================================

    // Count of beats already received per tag, minus nothing
    // A count equal to the stored length means this beat is the last one
    req_len_t cnt_ram [0:`EOP_MAX_ACTIVE_REQS-1];
    req_len_t rcvd_cnt;
    req_len_t cnt_upd;
    logic     ram_wen;
    tag_t     ram_waddr;
    req_len_t ram_wdata;

    assign rcvd_cnt = cnt_ram[rsp_tag];

    // End of packet is decided in the response cycle itself
    assign pkt_eop = rsp_en && (rcvd_cnt == rsp_len);

    // A completed packet returns its counter to zero so the tag can be reused
    assign cnt_upd = pkt_eop ? req_len_t'(0) : rcvd_cnt + req_len_t'(1);

    // Single write port shared by the sweep and the response path
    always_comb
    begin
        if (state == TRK_CLEAR)
        begin
            ram_wen   = 1'b1;
            ram_waddr = clear_idx;
            ram_wdata = '0;
        end
        else
        begin
            ram_wen   = rsp_en;
            ram_waddr = rsp_tag;
            ram_wdata = cnt_upd;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ram_wen)
        begin
            cnt_ram[ram_waddr] <= ram_wdata;
        end
    end

    // Responses may only come for requests issued after the sweep ended
    assert property (@(posedge clk) disable iff (reset)
        rsp_en |-> state == TRK_READY)
        else $error("flit_tracker: response beat during clearing sweep");

    // More beats than the request asked for means a lost or duplicated tag
    assert property (@(posedge clk) disable iff (reset)
        rsp_en |-> rcvd_cnt <= rsp_len)
        else $error("flit_tracker: beat count exceeds packet length");

endmodule

//--- hw/mem_req_pkg.sv
/* Request-side types for the end-of-packet shim: the request tag and the
   packet length of a request */

`include "eop_config.svh"

package mem_req_pkg;

    // Tag carried by a request and echoed by every response beat
    // Tags are unique among the packets in flight on one channel
    typedef logic [`EOP_TAG_BITS-1:0] tag_t;

    // Packet length of a request, encoded as number of beats minus one
    // A value of zero is a single cache line, three is four lines
    typedef logic [`EOP_LEN_BITS-1:0] req_len_t;

endpackage

//--- hw/mem_rsp_pkg.sv
/* Response-side types for the end-of-packet shim: beat number, write
   response format and the state of a beat tracker */

`include "eop_config.svh"

package mem_rsp_pkg;

    // Beat number of a response within its packet
    // A packed write response puts the packet length here instead
    typedef logic [`EOP_LEN_BITS-1:0] cl_num_t;

    // Format of a write response
    // WR_FMT_BEAT acknowledges a single cache line of a packet,
    // WR_FMT_PACKED acknowledges the whole packet at once
    typedef enum logic
    {
        WR_FMT_BEAT   = 1'b0,
        WR_FMT_PACKED = 1'b1
    } wr_fmt_e;

    // State of a beat tracker
    // The counter RAM is swept to zero in TRK_CLEAR before use
    typedef enum logic
    {
        TRK_CLEAR = 1'b0,
        TRK_READY = 1'b1
    } trk_state_e;

endpackage

//--- hw/req_len_table.sv
/* Request length table: remembers the packet length of each request under
   its tag and returns it for the tag of the current response */

`timescale 1ns/1ps

`include "eop_config.svh"

module req_len_table
    import mem_req_pkg::*;
(
    input  logic     clk,

    // Request being issued by the user logic
    input  logic     req_en,
    input  tag_t     req_tag,
    input  req_len_t req_len,

    // Tag of the response seen in this cycle
    input  tag_t     rsp_tag,
    output req_len_t rsp_len
);

    // One length entry per tag
    // This is a small distributed RAM with a single write port, owned only
    // by the request side, while the beat counters live in the tracker
    req_len_t len_ram [0:`EOP_MAX_ACTIVE_REQS-1];

    // Capture the length on the request cycle
    // An entry is rewritten only when its tag is issued again, which
    // cannot happen before the previous packet with that tag is complete
    always_ff @(posedge clk)
    begin
        if (req_en)
        begin
            len_ram[req_tag] <= req_len;
        end
    end

    // Asynchronous read by response tag
    // A response arrives at least one cycle after its request, so the
    // entry written at the request edge is already visible here
    assign rsp_len = len_ram[rsp_tag];

endmodule

//--- hw/rsp_eop_stage.sv
/* Response stage: registers read beats with their end-of-packet flag and
   merges per-beat write responses into a single packed response */

`timescale 1ns/1ps

`include "eop_config.svh"

module rsp_eop_stage
    import mem_req_pkg::*;
    import mem_rsp_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    // Read beat from memory and its end flag from the read tracker
    input  logic                      mem_rd_rsp_valid,
    input  tag_t                      mem_rd_rsp_tag,
    input  cl_num_t                   mem_rd_rsp_cl_num,
    input  logic [`EOP_DATA_BITS-1:0] mem_rd_rsp_data,
    input  logic                      rd_eop,

    // Write response from memory, its end flag and its stored length
    input  logic                      mem_wr_rsp_valid,
    input  tag_t                      mem_wr_rsp_tag,
    input  wr_fmt_e                   mem_wr_rsp_fmt,
    input  cl_num_t                   mem_wr_rsp_cl_num,
    input  logic                      wr_eop,
    input  req_len_t                  wr_len,

    // Write beats that the write tracker has to count
    output logic                      wr_beat_en,

    // Read beats toward the user
    output logic                      user_rd_rsp_valid,
    output tag_t                      user_rd_rsp_tag,
    output cl_num_t                   user_rd_rsp_cl_num,
    output logic [`EOP_DATA_BITS-1:0] user_rd_rsp_data,
    output logic                      user_rd_rsp_eop,

    // Merged write responses toward the user
    output logic                      user_wr_rsp_valid,
    output tag_t                      user_wr_rsp_tag,
    output wr_fmt_e                   user_wr_rsp_fmt,
    output cl_num_t                   user_wr_rsp_cl_num
);

    logic wr_final;

    // ========================================================================
    // Read path
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            user_rd_rsp_valid <= 1'b0;
        end
        else
        begin
            user_rd_rsp_valid <= mem_rd_rsp_valid;
        end
    end

    // Beat payload goes through unchanged, only the end flag is added
    always_ff @(posedge clk)
    begin
        if (mem_rd_rsp_valid)
        begin
            user_rd_rsp_tag    <= mem_rd_rsp_tag;
            user_rd_rsp_cl_num <= mem_rd_rsp_cl_num;
            user_rd_rsp_data   <= mem_rd_rsp_data;
            user_rd_rsp_eop    <= rd_eop;
        end
    end

    // ========================================================================
    // Write path
    // ========================================================================

    // Packed responses are complete already and never touch the counters
    assign wr_beat_en = mem_wr_rsp_valid && (mem_wr_rsp_fmt == WR_FMT_BEAT);

    // Final when packed by memory, or when the beat closes its packet
    assign wr_final = mem_wr_rsp_valid && ((mem_wr_rsp_fmt == WR_FMT_PACKED) || wr_eop);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            user_wr_rsp_valid <= 1'b0;
        end
        else
        begin
            // Earlier beats of a packet are dropped here
            user_wr_rsp_valid <= wr_final;
        end
    end

    // Every response that reaches the user describes a whole packet
    always_ff @(posedge clk)
    begin
        if (wr_final)
        begin
            user_wr_rsp_tag    <= mem_wr_rsp_tag;
            user_wr_rsp_fmt    <= WR_FMT_PACKED;
            user_wr_rsp_cl_num <= cl_num_t'(wr_len);
        end
    end

    // A beat number beyond the length recorded for its tag is a stray beat
    assert property (@(posedge clk) disable iff (reset)
        wr_beat_en |-> mem_wr_rsp_cl_num <= wr_len)
        else $error("rsp_eop_stage: write beat number beyond packet length");

endmodule

//--- src.f
+incdir+hw
hw/mem_req_pkg.sv
hw/mem_rsp_pkg.sv
hw/req_len_table.sv
hw/flit_tracker.sv
hw/rsp_eop_stage.sv
hw/eop_shim_top.sv
dv/eop_shim_tb.sv
